// File: src/cache_pkg.sv
package cache_pkg;

    // address split is tag[19:0] | index[7:0] | offset[3:0]
    typedef logic [7:0]   index_t;
    typedef logic [19:0]  tag_t;
    typedef logic [3:0]   offset_t;
    typedef logic [1:0]   bank_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;
    typedef logic [3:0]   wstrb_t;
    typedef logic         way_t;

    localparam int WAYS  = 2;
    localparam int BANKS = 4;
    localparam int SETS  = 256;

    // request as held by the controller during lookup and miss handling
    typedef struct packed {
        logic    op;
        index_t  index;
        tag_t    tag;
        offset_t offset;
        wstrb_t  wstrb;
        word_t   wdata;
    } cpu_req_t;

    // tag store answer for the registered index
    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

    // one pending bank write
    typedef struct packed {
        way_t   way;
        index_t index;
        bank_t  bank;
        wstrb_t wstrb;
        word_t  wdata;
    } wbuf_t;

    typedef enum logic [4:0] {
        IDLE      = 5'b00001,
        LOOKUP    = 5'b00010,
        WRITEBACK = 5'b00100,
        REPLACE   = 5'b01000,
        REFILL    = 5'b10000
    } main_state_t;

    typedef enum logic [1:0] {
        WB_IDLE  = 2'b01,
        WB_WRITE = 2'b10
    } wbuf_state_t;

endpackage

// File: src/cache_tag_store.sv
module cache_tag_store import cache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  index_t  rd_index,
    input  tag_t    req_tag,
    input  logic    touch,
    input  way_t    touch_way,
    input  logic    fill,
    input  way_t    fill_way,
    input  logic    fill_dirty,
    input  logic    set_dirty,
    input  way_t    set_dirty_way,
    output lookup_t lookup
);

    index_t index_q;
    tag_t   way_tag [WAYS];
    logic   [WAYS-1:0][SETS-1:0] valid_bits;
    logic   [WAYS-1:0][SETS-1:0] dirty_bits;
    // least recently used way of each set
    logic   [SETS-1:0] lru_bits;
    logic   [WAYS-1:0] way_valid;
    logic   [WAYS-1:0] way_dirty;
    logic   [WAYS-1:0] way_hit;
    way_t   victim;

    // all state is looked up at the index of the previous cycle
    always_ff @(posedge clk)
    begin
        index_q <= rd_index;
    end

    for (genvar w = 0; w < WAYS; w++)
    begin : g_way
        tag_t tag_ram [SETS];
        tag_t tag_q;

        always_ff @(posedge clk)
        begin
            if (fill && fill_way == way_t'(w))
            begin
                tag_ram[index_q] <= req_tag;
            end
            tag_q <= tag_ram[rd_index];
        end

        assign way_tag[w]   = tag_q;
        assign way_valid[w] = valid_bits[w][index_q];
        assign way_dirty[w] = dirty_bits[w][index_q];
        assign way_hit[w]   = way_valid[w] && (tag_q == req_tag);
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits   <= '0;
        end
        else
        begin
            if (fill)
            begin
                valid_bits[fill_way][index_q] <= 1'b1;
                dirty_bits[fill_way][index_q] <= fill_dirty;
                lru_bits[index_q]             <= ~fill_way;
            end
            else if (touch)
            begin
                lru_bits[index_q] <= ~touch_way;
            end
            if (set_dirty)
            begin
                dirty_bits[set_dirty_way][index_q] <= 1'b1;
            end
        end
    end

    // empty ways are filled before anything is evicted
    always_comb
    begin
        if (!way_valid[0])
            victim = 1'b0;
        else if (!way_valid[1])
            victim = 1'b1;
        else
            victim = lru_bits[index_q];
    end

    always_comb
    begin
        lookup.hit          = |way_hit;
        lookup.hit_way      = way_hit[1];
        lookup.victim_way   = victim;
        lookup.victim_dirty = way_valid[victim] && way_dirty[victim];
        lookup.victim_tag   = way_tag[victim];
    end

endmodule

// File: src/cache_data_store.sv
module cache_data_store import cache_pkg::*; (
    input  logic   clk,
    input  index_t rd_index,
    input  logic   wbuf_en,
    input  wbuf_t  wbuf,
    input  logic   beat_en,
    input  way_t   beat_way,
    input  index_t beat_index,
    input  bank_t  beat_bank,
    input  word_t  beat_data,
    output line_t  way0_line,
    output line_t  way1_line
);

    // bank 0 sits in the low word of each line
    word_t [BANKS-1:0] rd_word [WAYS];

    for (genvar w = 0; w < WAYS; w++)
    begin : g_way
        for (genvar b = 0; b < BANKS; b++)
        begin : g_bank
            word_t  bank_ram [SETS];
            word_t  rd_q;
            logic   beat_sel;
            logic   wbuf_sel;
            wstrb_t wr_be;
            index_t wr_addr;
            word_t  wr_word;

            assign beat_sel = beat_en && beat_way == way_t'(w) && beat_bank == bank_t'(b);
            assign wbuf_sel = wbuf_en && wbuf.way == way_t'(w) && wbuf.bank == bank_t'(b);

            // refill beats write full words while buffer writes are byte masked
            assign wr_be   = beat_sel ? 4'hf : (wbuf_sel ? wbuf.wstrb : 4'h0);
            assign wr_addr = beat_sel ? beat_index : wbuf.index;
            assign wr_word = beat_sel ? beat_data : wbuf.wdata;

            always_ff @(posedge clk)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (wr_be[i])
                    begin
                        bank_ram[wr_addr][8*i +: 8] <= wr_word[8*i +: 8];
                    end
                end
                rd_q <= bank_ram[rd_index];
            end

            assign rd_word[w][b] = rd_q;
        end
    end

    assign way0_line = rd_word[0];
    assign way1_line = rd_word[1];

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // cpu side
    input  logic        valid,
    input  cpu_req_t    req,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    // tag and data stores
    output index_t      rd_index,
    output tag_t        req_tag,
    input  lookup_t     lookup,
    input  line_t       way0_line,
    input  line_t       way1_line,
    output logic        touch,
    output way_t        touch_way,
    output logic        fill,
    output way_t        fill_way,
    output logic        fill_dirty,
    output logic        set_dirty,
    output way_t        set_dirty_way,
    output logic        wbuf_en,
    output wbuf_t       wbuf,
    output logic        beat_en,
    output way_t        beat_way,
    output index_t      beat_index,
    output bank_t       beat_bank,
    output word_t       beat_data,
    // memory bus
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    input  logic        wr_rdy
);

    main_state_t state;
    main_state_t state_next;
    wbuf_state_t wb_state;
    wbuf_state_t wb_state_next;
    cpu_req_t    req_q;
    bank_t       req_bank;
    logic        in_lookup;
    logic        store_hit;
    logic        refill_done;
    logic        wb_load;
    way_t        victim_way_q;
    tag_t        victim_tag_q;
    line_t       victim_line_q;
    bank_t       beat_cnt;
    word_t       refill_word;
    logic        refill_ok;
    line_t       hit_line;

    assign req_bank    = req_q.offset[3:2];
    assign in_lookup   = state == LOOKUP;
    assign store_hit   = in_lookup && lookup.hit && req_q.op;
    assign refill_done = state == REFILL && ret_valid && ret_last;
    // store hit or store miss merge once the line is back
    assign wb_load     = store_hit || (refill_done && req_q.op);

    // a new request may follow a load hit directly
    assign addr_ok = valid && wb_state == WB_IDLE &&
                     (state == IDLE || (in_lookup && lookup.hit && !req_q.op));

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (addr_ok)
                    state_next = LOOKUP;
            end
            LOOKUP:
            begin
                if (lookup.hit)
                    state_next = addr_ok ? LOOKUP : IDLE;
                else if (lookup.victim_dirty)
                    state_next = WRITEBACK;
                else
                    state_next = REPLACE;
            end
            WRITEBACK:
            begin
                if (wr_rdy)
                    state_next = REPLACE;
            end
            REPLACE:
            begin
                if (rd_rdy)
                    state_next = REFILL;
            end
            REFILL:
            begin
                if (ret_valid && ret_last)
                    state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    assign wb_state_next = wb_load ? WB_WRITE : WB_IDLE;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state     <= IDLE;
            wb_state  <= WB_IDLE;
            refill_ok <= 1'b0;
            beat_cnt  <= '0;
        end
        else
        begin
            state     <= state_next;
            wb_state  <= wb_state_next;
            // load miss answers the cycle after the last beat
            refill_ok <= refill_done && !req_q.op;
            if (refill_done)
                beat_cnt <= '0;
            else if (beat_en)
                beat_cnt <= beat_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (addr_ok)
            req_q <= req;
        // victim line read out during lookup and kept for the write-back
        if (in_lookup && !lookup.hit)
        begin
            victim_way_q  <= lookup.victim_way;
            victim_tag_q  <= lookup.victim_tag;
            victim_line_q <= lookup.victim_way ? way1_line : way0_line;
        end
        if (beat_en && beat_cnt == req_bank)
            refill_word <= ret_data;
        if (wb_load)
        begin
            wbuf.way   <= store_hit ? lookup.hit_way : victim_way_q;
            wbuf.index <= req_q.index;
            wbuf.bank  <= req_bank;
            wbuf.wstrb <= req_q.wstrb;
            wbuf.wdata <= req_q.wdata;
        end
    end

    // stores read at the port index in an accepting cycle
    assign rd_index = addr_ok ? req.index : req_q.index;
    assign req_tag  = req_q.tag;

    assign hit_line = lookup.hit_way ? way1_line : way0_line;
    assign rdata    = refill_ok ? refill_word : hit_line[32*req_bank +: 32];
    // stores are answered in lookup whether they hit or not
    assign data_ok  = (in_lookup && (req_q.op || lookup.hit)) || refill_ok;

    assign touch         = in_lookup && lookup.hit;
    assign touch_way     = lookup.hit_way;
    assign set_dirty     = store_hit;
    assign set_dirty_way = lookup.hit_way;
    assign fill          = refill_done;
    assign fill_way      = victim_way_q;
    assign fill_dirty    = req_q.op;

    assign wbuf_en    = wb_state == WB_WRITE;
    assign beat_en    = state == REFILL && ret_valid;
    assign beat_way   = victim_way_q;
    assign beat_index = req_q.index;
    assign beat_bank  = beat_cnt;
    assign beat_data  = ret_data;

    assign rd_req  = state == REPLACE;
    assign rd_addr = {req_q.tag, req_q.index, 4'b0};
    assign wr_req  = state == WRITEBACK;
    assign wr_addr = {victim_tag_q, req_q.index, 4'b0};
    assign wr_data = victim_line_q;

endmodule

// File: src/cache_top.sv
module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // cpu pipeline
    input  logic        valid,
    input  logic        op,
    input  index_t      index,
    input  tag_t        tag,
    input  offset_t     offset,
    input  wstrb_t      wstrb,
    input  word_t       wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    // line read
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    // line write
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    input  logic        wr_rdy
);

    cpu_req_t req;
    index_t   rd_index;
    tag_t     req_tag;
    lookup_t  lookup;
    line_t    way0_line;
    line_t    way1_line;
    logic     touch;
    way_t     touch_way;
    logic     fill;
    way_t     fill_way;
    logic     fill_dirty;
    logic     set_dirty;
    way_t     set_dirty_way;
    logic     wbuf_en;
    wbuf_t    wbuf;
    logic     beat_en;
    way_t     beat_way;
    index_t   beat_index;
    bank_t    beat_bank;
    word_t    beat_data;

    assign req = '{op: op, index: index, tag: tag, offset: offset, wstrb: wstrb, wdata: wdata};

    cache_tag_store u_tag_store (
        .clk           (clk),
        .resetn        (resetn),
        .rd_index      (rd_index),
        .req_tag       (req_tag),
        .touch         (touch),
        .touch_way     (touch_way),
        .fill          (fill),
        .fill_way      (fill_way),
        .fill_dirty    (fill_dirty),
        .set_dirty     (set_dirty),
        .set_dirty_way (set_dirty_way),
        .lookup        (lookup)
    );

    cache_data_store u_data_store (
        .clk        (clk),
        .rd_index   (rd_index),
        .wbuf_en    (wbuf_en),
        .wbuf       (wbuf),
        .beat_en    (beat_en),
        .beat_way   (beat_way),
        .beat_index (beat_index),
        .beat_bank  (beat_bank),
        .beat_data  (beat_data),
        .way0_line  (way0_line),
        .way1_line  (way1_line)
    );

    cache_ctrl u_ctrl (
        .clk (clk), .resetn (resetn),
        .valid (valid), .req (req), .addr_ok (addr_ok), .data_ok (data_ok), .rdata (rdata),
        .rd_index (rd_index), .req_tag (req_tag), .lookup (lookup),
        .way0_line (way0_line), .way1_line (way1_line),
        .touch (touch), .touch_way (touch_way),
        .fill (fill), .fill_way (fill_way), .fill_dirty (fill_dirty),
        .set_dirty (set_dirty), .set_dirty_way (set_dirty_way),
        .wbuf_en (wbuf_en), .wbuf (wbuf),
        .beat_en (beat_en), .beat_way (beat_way), .beat_index (beat_index),
        .beat_bank (beat_bank), .beat_data (beat_data),
        .rd_req (rd_req), .rd_addr (rd_addr), .rd_rdy (rd_rdy),
        .ret_valid (ret_valid), .ret_last (ret_last), .ret_data (ret_data),
        .wr_req (wr_req), .wr_addr (wr_addr), .wr_data (wr_data), .wr_rdy (wr_rdy)
    );

endmodule

// File: testbench/cache_properties.sv
module cache_properties import cache_pkg::*; (
    input logic        clk,
    input logic        resetn,
    input logic        valid,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        rd_req,
    input logic [31:0] rd_addr,
    input logic        rd_rdy,
    input logic        wr_req,
    input logic [31:0] wr_addr,
    input line_t       wr_data,
    input logic        wr_rdy
);

    // accepted requests still waiting for data_ok
    int pending;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            pending <= 0;
        else
            pending <= pending + int'(valid && addr_ok) - int'(data_ok);
    end

    rd_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else $error("rd_req dropped or rd_addr changed before acceptance");

    wr_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else $error("wr_req dropped or write line changed before acceptance");

    no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
    else $error("rd_req and wr_req high together");

    ok_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> pending > 0)
    else $error("data_ok without an outstanding request");

endmodule

bind cache_ctrl cache_properties props (
    .clk     (clk),
    .resetn  (resetn),
    .valid   (valid),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_rdy  (rd_rdy),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_rdy  (wr_rdy)
);

// File: testbench/cache_tb.sv
module cache_tb import cache_pkg::*; ();

    localparam int PERIOD         = 40;
    localparam int NUM_REQ        = 400;
    localparam int CYCLES_PER_REQ = 60;
    // directed requests at the start of the run
    localparam int NUM_DIRECTED   = 6;

    logic        clk;
    logic        resetn;
    logic        valid;
    logic        op;
    index_t      index;
    tag_t        tag;
    offset_t     offset;
    wstrb_t      wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy;

    // bus memory and CPU view of it keyed by word address
    word_t mem_words [int unsigned];
    word_t shadow    [int unsigned];
    logic  exp_is_load [$];
    word_t exp_data    [$];
    int    rd_count;

    cache_top dut (.*);

    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

    // initial memory pattern over the whole address
    function automatic word_t init_word(input logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic word_t mem_word(input logic [31:0] addr);
        if (mem_words.exists(addr[31:2]))
            return mem_words[addr[31:2]];
        return init_word({addr[31:2], 2'b00});
    endfunction

    // reference model of what a load must return
    function automatic word_t expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2]))
            return shadow[addr[31:2]];
        return init_word({addr[31:2], 2'b00});
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t new_word,
                                          input wstrb_t mask);
        word_t result;
        result = old;
        for (int i = 0; i < 4; i++)
        begin
            if (mask[i])
                result[8*i +: 8] = new_word[8*i +: 8];
        end
        return result;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    // runs from a falling edge to the falling edge after acceptance
    task automatic send_request(input logic is_store, input tag_t t, input index_t idx,
                                input bank_t b, input wstrb_t mask, input word_t data);
        logic [31:0] addr;
        addr   = {t, idx, b, 2'b00};
        valid  = 1'b1;
        op     = is_store;
        tag    = t;
        index  = idx;
        offset = {b, 2'b00};
        wstrb  = mask;
        wdata  = data;
        #(PERIOD / 4);
        while (!addr_ok)
        begin
            @(negedge clk);
            #(PERIOD / 4);
        end
        exp_is_load.push_back(!is_store);
        if (is_store)
        begin
            shadow[addr[31:2]] = merge_bytes(expected_word(addr), data, mask);
            exp_data.push_back('0);
        end
        else
        begin
            exp_data.push_back(expected_word(addr));
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_is_load.size() != 0)
            @(negedge clk);
    endtask

    // read port answers a random rd_rdy with four beats and random gaps
    initial
    begin : read_port
        logic [31:0] line_addr;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rd_count  = 0;
        forever
        begin
            @(negedge clk);
            rd_rdy = ($urandom_range(0, 2) == 0);
            #(PERIOD / 4);
            if (resetn && rd_req && rd_rdy)
            begin
                line_addr = rd_addr;
                rd_count++;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++)
                begin
                    while ($urandom_range(0, 3) == 0)
                    begin
                        ret_valid = 1'b0;
                        @(negedge clk);
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = mem_word(line_addr + 32'(4 * b));
                    @(negedge clk);
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    // evicted lines on the write port must match the CPU view
    initial
    begin : write_port
        word_t exp_word;
        wr_rdy = 1'b0;
        forever
        begin
            @(negedge clk);
            wr_rdy = ($urandom_range(0, 2) == 0);
            #(PERIOD / 4);
            if (resetn && wr_req && wr_rdy)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    exp_word = expected_word(wr_addr + 32'(4 * b));
                    assert (wr_data[32*b +: 32] == exp_word)
                    else
                        stop_on_error($sformatf(
                            "MISMATCH at %0t: wr_data bank %0d got %h expected %h",
                            $time, b, wr_data[32*b +: 32], exp_word));
                    mem_words[(wr_addr >> 2) + 32'(b)] = wr_data[32*b +: 32];
                end
            end
        end
    end

    // compare each data_ok with the oldest outstanding request
    initial
    begin : compare
        logic  is_load;
        word_t exp;
        forever
        begin
            @(posedge clk);
            #(PERIOD / 4);
            if (resetn && data_ok)
            begin
                assert (exp_is_load.size() != 0)
                else
                    stop_on_error("data_ok arrived while no request was outstanding");
                is_load = exp_is_load.pop_front();
                exp     = exp_data.pop_front();
                if (is_load)
                begin
                    assert (rdata == exp)
                    else
                        stop_on_error($sformatf("MISMATCH at %0t: rdata got %h expected %h",
                                                $time, rdata, exp));
                end
            end
        end
    end

    initial
    begin : watchdog
        #((NUM_REQ + NUM_DIRECTED) * CYCLES_PER_REQ * PERIOD);
        $display("timeout: the requests did not all complete in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin : stimulus
        int reads_before;
        void'($urandom(15));
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // fresh line followed by a repeat that must hit
        send_request(1'b0, 20'h0abcd, 8'h77, 2'd1, 4'h0, '0);
        wait_drained();
        assert (rd_count == 1)
        else
            stop_on_error("the first load to an untouched line issued no line read");
        reads_before = rd_count;
        send_request(1'b0, 20'h0abcd, 8'h77, 2'd2, 4'h0, '0);
        wait_drained();
        assert (rd_count == reads_before)
        else
            stop_on_error("a repeated load to a just filled line issued a line read");

        // store hit and store miss each followed by a load
        send_request(1'b1, 20'h0abcd, 8'h77, 2'd1, 4'b0110, 32'h1234_5678);
        send_request(1'b0, 20'h0abcd, 8'h77, 2'd1, 4'h0, '0);
        send_request(1'b1, 20'h0abce, 8'h77, 2'd3, 4'b1001, 32'hcafe_f00d);
        send_request(1'b0, 20'h0abce, 8'h77, 2'd3, 4'h0, '0);
        wait_drained();

        // four tags over four sets forces evictions of dirty lines
        for (int i = 0; i < NUM_REQ; i++)
        begin
            send_request($urandom_range(0, 1) == 1,
                         20'h00040 + 20'($urandom_range(0, 3)),
                         8'h10 + 8'($urandom_range(0, 3)),
                         2'($urandom_range(0, 3)),
                         4'($urandom_range(1, 15)),
                         $urandom());
            if ($urandom_range(0, 3) == 0)
                @(negedge clk);
        end
        wait_drained();
        repeat (4) @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: sources.f
src/cache_pkg.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/cache_properties.sv
testbench/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f sources.f \
    -o cache_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1 || grep -q "Test completed successfully" sim.log \
    && exit 0 || exit 1
